/* logic/fb_cfg_pkg.sv */
// frame geometry, slot count and register map; imported by every frame buffer block
package fb_cfg_pkg;

	localparam int PIX_WIDTH   = 16;                   // bits per pixel
	localparam int FRAME_W     = 8;                    // pixels per line
	localparam int FRAME_H     = 4;                    // lines per frame
	localparam int WORD_PIX    = 2;                    // pixels packed in one memory word
	localparam int FRAME_WORDS = FRAME_W * FRAME_H / WORD_PIX;
	localparam int SLOT_N      = 4;                    // slots in the ring at most
	localparam int SLOT_W      = 2;                    // slot index bits
	localparam int ADDR_W      = 6;                    // word address, slot index on top
	localparam int OFF_W       = ADDR_W - SLOT_W;      // word offset inside a slot
	localparam int COL_W       = $clog2(FRAME_W);      // column counter of the reader

	// apb register offsets
	localparam logic [7:0] REG_CTRL   = 8'h00; // en, pos_proc, irq mask
	localparam logic [7:0] REG_SLOTS  = 8'h04; // slots in use minus one
	localparam logic [7:0] REG_PROC   = 8'h08; // write 1 to release a held frame
	localparam logic [7:0] REG_STATUS = 8'h0C; // sticky status, write 1 to clear

	localparam int ST_FILLED  = 0;
	localparam int ST_FETCHED = 1;

	typedef struct packed {
		logic              en;         // buffer enable
		logic              pos_proc;   // hold frames until software marks them processed
		logic [SLOT_W-1:0] slots_sub1; // ring length minus one
		logic [1:0]        itr_en;     // indexed by ST_FILLED / ST_FETCHED
	} fb_cfg_t;

endpackage

/* logic/fb_stream_pkg.sv */
// pixel, memory word and stream beat types; imported by the data path blocks
package fb_stream_pkg;

	// bits in one memory word
	localparam int WORD_W = fb_cfg_pkg::PIX_WIDTH * fb_cfg_pkg::WORD_PIX;

	typedef logic [fb_cfg_pkg::PIX_WIDTH-1:0] pixel_t;

	// one memory word, plain bits for the ram or a pixel pair for pack / unpack
	// pix[0] sits in the low half and is the earlier pixel on the line
	typedef union packed {
		logic [WORD_W-1:0]                     raw;
		pixel_t [fb_cfg_pkg::WORD_PIX-1:0]     pix;
	} mem_word_u;

	// output stream beat
	typedef struct packed {
		pixel_t pix;
		logic   last; // end of line
	} vid_beat_t;

	// write port from the writer into the slot memory
	typedef struct packed {
		logic                          en;
		logic [fb_cfg_pkg::ADDR_W-1:0] addr; // {slot, word offset}
		mem_word_u                     data;
	} mem_wr_t;

endpackage

/* logic/fb_reg_if.sv */
// apb register block of the frame buffer, holds config, status and interrupt outputs
`timescale 1ns/100ps

module fb_reg_if (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [7:0]          paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output fb_cfg_pkg::fb_cfg_t cfg,
	output logic                processed,   // one cycle, to the store
	input  logic                filled,      // one cycle, from the store
	input  logic                fetched,     // one cycle, from the store
	output logic                irq_filled,
	output logic                irq_fetched
);
	import fb_cfg_pkg::*;

	logic       wr_acc;  // write in access phase
	logic       rd_acc;  // read in access phase
	logic [1:0] status;  // sticky, indexed by ST_*
	logic [1:0] st_set;
	logic [1:0] st_clr;

	assign wr_acc = psel & penable & pwrite;
	assign rd_acc = psel & penable & ~pwrite;

	// ctrl layout: bit 0 en, bit 1 pos_proc, bits 9:8 interrupt mask
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (wr_acc) begin
			if (paddr == REG_CTRL) begin
				cfg.en       <= pwdata[0];
				cfg.pos_proc <= pwdata[1];
				cfg.itr_en   <= pwdata[9:8];
			end
			if (paddr == REG_SLOTS) begin
				cfg.slots_sub1 <= pwdata[SLOT_W-1:0]; // upper bits ignored
			end
		end
	end

	// processed strobe, only bit 0 of the proc register counts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processed <= 1'b0;
		end else begin
			processed <= wr_acc & (paddr == REG_PROC) & pwdata[0];
		end
	end

	always_comb begin
		st_set             = '0;
		st_set[ST_FILLED]  = filled;
		st_set[ST_FETCHED] = fetched;
	end

	// w1c on status
	assign st_clr = (wr_acc && paddr == REG_STATUS) ? pwdata[1:0] : 2'b00;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status      <= '0;
			irq_filled  <= 1'b0;
			irq_fetched <= 1'b0;
		end else begin
			status      <= (status & ~st_clr) | st_set; // new event beats a clear
			irq_filled  <= status[ST_FILLED] & cfg.itr_en[ST_FILLED];
			irq_fetched <= status[ST_FETCHED] & cfg.itr_en[ST_FETCHED];
		end
	end

	// read mux, zero wait states
	always_comb begin
		prdata = '0;
		if (rd_acc) begin
			case (paddr)
				REG_CTRL: begin
					prdata[0]   = cfg.en;
					prdata[1]   = cfg.pos_proc;
					prdata[9:8] = cfg.itr_en;
				end
				REG_SLOTS:  prdata[SLOT_W-1:0] = cfg.slots_sub1;
				REG_STATUS: prdata[1:0]        = status;
				default:    prdata             = '0; // proc reads back zero
			endcase
		end
	end

endmodule

/* logic/frame_writer.sv */
// frame writer, packs input pixel pairs into words and writes them to the current slot
`timescale 1ns/100ps

module frame_writer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  fb_stream_pkg::pixel_t         vin_pix,
	input  logic                          vin_valid,
	output logic                          vin_ready,
	input  logic [fb_cfg_pkg::SLOT_W-1:0] wr_slot,
	input  logic                          wr_free,   // slot empty and buffer enabled
	output fb_stream_pkg::mem_wr_t        wr,
	output logic                          wr_done    // last word of the frame
);
	import fb_cfg_pkg::*;
	import fb_stream_pkg::*;

	logic             acc;       // pixel taken this cycle
	logic             odd;       // next pixel completes a word
	pixel_t           pix_hold;  // even pixel of the pair
	logic [OFF_W-1:0] word_cnt;  // word offset inside the frame
	logic             frame_end;

	// back-pressure comes straight from the store
	assign vin_ready = wr_free;
	assign acc       = vin_valid & wr_free;
	assign frame_end = (word_cnt == OFF_W'(FRAME_WORDS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			odd      <= 1'b0;
			word_cnt <= '0;
		end else if (acc) begin
			odd <= ~odd;
			if (odd) begin
				word_cnt <= frame_end ? '0 : word_cnt + 1'b1;
			end
		end
	end

	// first pixel of a pair just waits here
	always_ff @(posedge clk) begin
		if (acc && !odd) begin
			pix_hold <= vin_pix;
		end
	end

	// word goes out in the same cycle the odd pixel is accepted
	always_comb begin
		wr.en          = acc & odd;
		wr.addr        = {wr_slot, word_cnt}; // slot base + offset
		wr.data.pix[0] = pix_hold;            // earlier pixel, low half
		wr.data.pix[1] = vin_pix;
	end

	assign wr_done = acc & odd & frame_end;

endmodule

/* logic/frame_store.sv */
// slot memory and slot state ring, decides when a slot may be written or read
`timescale 1ns/100ps

module frame_store (
	input  logic                          clk,
	input  logic                          rst_n,
	input  fb_cfg_pkg::fb_cfg_t           cfg,
	input  fb_stream_pkg::mem_wr_t        wr,
	input  logic                          wr_done,
	output logic [fb_cfg_pkg::SLOT_W-1:0] wr_slot,
	output logic                          wr_free,
	input  logic                          rd_en,
	input  logic [fb_cfg_pkg::ADDR_W-1:0] rd_addr,
	input  logic                          rd_done,
	output logic [fb_cfg_pkg::SLOT_W-1:0] rd_slot,
	output logic                          rd_avail,
	output fb_stream_pkg::mem_word_u      rd_data,
	input  logic                          processed,
	output logic                          filled,   // frame closed by the writer
	output logic                          fetched   // frame drained by the reader
);
	import fb_cfg_pkg::*;
	import fb_stream_pkg::*;

	typedef enum logic [1:0] {
		SL_EMPTY,
		SL_FILLED,
		SL_PROC     // filled and released by software
	} slot_st_e;

	logic [WORD_W-1:0] mem [SLOT_N * FRAME_WORDS];
	slot_st_e          slot_st [SLOT_N];
	logic [SLOT_W-1:0] wr_ptr;
	logic [SLOT_W-1:0] rd_ptr;

	assign wr_slot = wr_ptr;
	assign rd_slot = rd_ptr;
	assign wr_free = cfg.en & (slot_st[wr_ptr] == SL_EMPTY);
	// pos_proc holds a filled frame back until processed
	assign rd_avail = cfg.pos_proc ? (slot_st[rd_ptr] == SL_PROC)
	                               : (slot_st[rd_ptr] != SL_EMPTY);

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data.raw;
		end
		if (rd_en) begin
			rd_data.raw <= mem[rd_addr]; // one cycle read, held until next rd_en
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SLOT_N; i++) begin
				slot_st[i] <= SL_EMPTY;
			end
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			filled  <= 1'b0;
			fetched <= 1'b0;
		end else begin
			filled  <= wr_done;
			fetched <= rd_done;
			// only a filled slot at the read side can be released
			if (processed && slot_st[rd_ptr] == SL_FILLED) begin
				slot_st[rd_ptr] <= SL_PROC;
			end
			if (wr_done) begin
				slot_st[wr_ptr] <= SL_FILLED;
				wr_ptr          <= (wr_ptr == cfg.slots_sub1) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_done) begin
				slot_st[rd_ptr] <= SL_EMPTY; // wins over a late processed
				rd_ptr          <= (rd_ptr == cfg.slots_sub1) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* logic/frame_reader.sv */
// frame reader, fetches words of the read slot and sends them out pixel by pixel
`timescale 1ns/100ps

module frame_reader (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [fb_cfg_pkg::SLOT_W-1:0] rd_slot,
	input  logic                          rd_avail,
	output logic                          rd_en,
	output logic [fb_cfg_pkg::ADDR_W-1:0] rd_addr,
	input  fb_stream_pkg::mem_word_u      rd_data,
	output logic                          rd_done,   // last pixel of the frame taken
	output fb_stream_pkg::vid_beat_t      vout,
	output logic                          vout_valid,
	input  logic                          vout_ready
);
	import fb_cfg_pkg::*;
	import fb_stream_pkg::*;

	logic             cur_vld;   // word being unpacked
	mem_word_u        cur_word;
	logic             half;      // which pixel of cur_word is on the bus
	logic             pend_vld;  // store rd_data holds a word not yet claimed
	logic             pend_move; // pending word moves into cur_word
	logic             beat_acc;
	logic             word_done;
	logic [OFF_W-1:0] iss_cnt;   // next word offset to request
	logic             iss_all;   // whole frame requested
	logic [OFF_W-1:0] out_cnt;   // words fully sent
	logic [COL_W-1:0] col;

	assign beat_acc  = cur_vld & vout_ready;
	assign word_done = beat_acc & half;
	assign pend_move = pend_vld & (~cur_vld | word_done);

	// read ahead while a word place is free
	assign rd_en   = rd_avail & ~iss_all & (~pend_vld | pend_move);
	assign rd_addr = {rd_slot, iss_cnt};
	assign rd_done = word_done & (out_cnt == OFF_W'(FRAME_WORDS - 1));

	assign vout_valid = cur_vld;
	assign vout.pix   = cur_word.pix[half]; // pix[0] first
	assign vout.last  = (col == COL_W'(FRAME_W - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_vld  <= 1'b0;
			half     <= 1'b0;
			pend_vld <= 1'b0;
			iss_cnt  <= '0;
			iss_all  <= 1'b0;
			out_cnt  <= '0;
			col      <= '0;
		end else begin
			pend_vld <= rd_en | (pend_vld & ~pend_move); // data lands next cycle
			if (pend_move) begin
				cur_vld <= 1'b1;
			end else if (word_done) begin
				cur_vld <= 1'b0;
			end
			if (beat_acc) begin
				half <= ~half;
				col  <= vout.last ? '0 : col + 1'b1;
			end
			if (word_done) begin
				out_cnt <= rd_done ? '0 : out_cnt + 1'b1;
			end
			if (rd_en) begin
				if (iss_cnt == OFF_W'(FRAME_WORDS - 1)) begin
					iss_cnt <= '0;
					iss_all <= 1'b1; // stop until this frame is drained
				end else begin
					iss_cnt <= iss_cnt + 1'b1;
				end
			end
			if (rd_done) begin
				iss_all <= 1'b0; // next slot from the following cycle
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pend_move) begin
			cur_word <= rd_data;
		end
	end

endmodule

/* logic/frame_buffer.sv */
// frame buffer top level, wires the register block, writer, slot store and reader
`timescale 1ns/100ps

module frame_buffer (
	input  logic                     clk,
	input  logic                     rst_n,
	// apb
	input  logic [7:0]               paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [31:0]              pwdata,
	output logic [31:0]              prdata,
	// input pixel stream
	input  fb_stream_pkg::pixel_t    vin_pix,
	input  logic                     vin_valid,
	output logic                     vin_ready,
	// output pixel stream
	output fb_stream_pkg::vid_beat_t vout,
	output logic                     vout_valid,
	input  logic                     vout_ready,
	// interrupts
	output logic                     irq_filled,
	output logic                     irq_fetched
);
	import fb_cfg_pkg::*;
	import fb_stream_pkg::*;

	fb_cfg_t           cfg;
	logic              processed;
	logic              filled;
	logic              fetched;
	mem_wr_t           wr;        // writer to store
	logic              wr_done;
	logic [SLOT_W-1:0] wr_slot;
	logic              wr_free;
	logic              rd_en;     // reader to store
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_done;
	logic [SLOT_W-1:0] rd_slot;
	logic              rd_avail;
	mem_word_u         rd_data;

	fb_reg_if i_fb_reg_if (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata),
		.cfg(cfg), .processed(processed), .filled(filled), .fetched(fetched),
		.irq_filled(irq_filled), .irq_fetched(irq_fetched)
	);

	frame_writer i_frame_writer (
		.clk(clk), .rst_n(rst_n),
		.vin_pix(vin_pix), .vin_valid(vin_valid), .vin_ready(vin_ready),
		.wr_slot(wr_slot), .wr_free(wr_free), .wr(wr), .wr_done(wr_done)
	);

	frame_store i_frame_store (
		.clk(clk), .rst_n(rst_n), .cfg(cfg),
		.wr(wr), .wr_done(wr_done), .wr_slot(wr_slot), .wr_free(wr_free),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_done(rd_done),
		.rd_slot(rd_slot), .rd_avail(rd_avail), .rd_data(rd_data),
		.processed(processed), .filled(filled), .fetched(fetched)
	);

	frame_reader i_frame_reader (
		.clk(clk), .rst_n(rst_n),
		.rd_slot(rd_slot), .rd_avail(rd_avail), .rd_en(rd_en), .rd_addr(rd_addr),
		.rd_data(rd_data), .rd_done(rd_done),
		.vout(vout), .vout_valid(vout_valid), .vout_ready(vout_ready)
	);

endmodule

/* bench/frame_buffer_tb.sv */
// testbench for the frame buffer, drives apb and both pixel streams and checks by assertions
`timescale 1ns/100ps

module frame_buffer_tb;
	import fb_cfg_pkg::*;
	import fb_stream_pkg::*;

	localparam int FRAME_PIX    = FRAME_W * FRAME_H;
	localparam int SLOTS_S      = 2;                   // slots_sub1 in the back-pressure test
	localparam int RUN_FRAMES   = SLOTS_S + 1 + 4 + 1 + 1;
	localparam int WATCHDOG_CYC = RUN_FRAMES * FRAME_WORDS * 40;
	localparam int GAP_LEN      = 256;
	localparam int RDY_LOW      = 0;
	localparam int RDY_HIGH     = 1;
	localparam int RDY_GAPS     = 2;

	logic        clk;
	logic        rst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	pixel_t      vin_pix;
	logic        vin_valid;
	logic        vin_ready;
	vid_beat_t   vout;
	logic        vout_valid;
	logic        vout_ready;
	logic        irq_filled;
	logic        irq_fetched;

	pixel_t exp_q [$];       // scoreboard, accepted input pixels in order
	pixel_t exp_pix;
	int     in_cnt;
	int     out_cnt;
	int     val_errs;
	int     proto_errs;
	int     ready_mode;
	bit     gap_pat [GAP_LEN]; // output ready pattern, filled from the seeded stream
	int     gap_idx;
	logic   dis_chk;         // buffer disabled phase
	logic   full_chk;        // all slots filled, input must stall
	logic   hold_chk;        // frame waits for processed
	logic   irq_off;         // interrupt mask is zero
	logic [31:0] rd_word;

	frame_buffer i_frame_buffer (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_value_error(input string msg);
		val_errs++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic report_protocol_error(input string msg);
		proto_errs++;
		$display("error %0t: %s", $time, msg);
	endtask

	// all tasks start and end 1 ns after a rising edge
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1 penable = 1'b1; // access phase
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1 penable = 1'b1;
		@(negedge clk);
		data = prdata; // combinational, stable mid cycle
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_status(input logic [1:0] exp);
		apb_read(REG_STATUS, rd_word);
		assert (rd_word == {30'd0, exp})
		else report_value_error($sformatf("status read %h, expected %h", rd_word, exp));
	endtask

	task automatic drive_pixels(input int n);
		for (int k = 0; k < n; k++) begin
			vin_pix   = pixel_t'($urandom);
			vin_valid = 1'b1;
			@(negedge clk);
			while (!vin_ready) @(negedge clk); // transfer on the next rising edge
			@(posedge clk);
			#1;
		end
		vin_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (out_cnt != in_cnt) @(negedge clk);
		@(posedge clk);
		#1;
	endtask

	// output ready, driven just after the edge
	always @(posedge clk) begin
		#1;
		case (ready_mode)
			RDY_LOW:  vout_ready = 1'b0;
			RDY_HIGH: vout_ready = 1'b1;
			default: begin
				vout_ready = gap_pat[gap_idx];
				gap_idx    = (gap_idx + 1) % GAP_LEN;
			end
		endcase
	end

	// stream monitor, mid cycle so the next edge decides the transfer
	always @(negedge clk) begin
		if (rst_n && vin_valid && vin_ready) begin
			exp_q.push_back(vin_pix);
			in_cnt++;
		end
		if (rst_n && vout_valid && vout_ready) begin
			if (exp_q.size() == 0) begin
				report_protocol_error("output pixel sent with no input pixel left to match");
			end else begin
				exp_pix = exp_q.pop_front();
				assert (vout.pix == exp_pix)
				else report_value_error($sformatf("pixel %0d is %h, expected %h",
					out_cnt, vout.pix, exp_pix));
			end
			assert (vout.last == ((out_cnt % FRAME_W) == FRAME_W - 1))
			else report_value_error($sformatf("last flag %b on pixel %0d", vout.last, out_cnt));
			out_cnt++;
		end
	end

	a_disabled: assert property (@(posedge clk) disable iff (!rst_n)
		dis_chk |-> !vin_ready && !vout_valid && !irq_filled && !irq_fetched)
	else report_protocol_error("buffer active while disabled");

	a_stall: assert property (@(posedge clk) disable iff (!rst_n) full_chk |-> !vin_ready)
	else report_protocol_error("input accepted with every slot full");

	a_stable: assert property (@(posedge clk) disable iff (!rst_n)
		vout_valid && !vout_ready |=> vout_valid && $stable(vout))
	else report_protocol_error("output beat changed while stalled");

	a_hold: assert property (@(posedge clk) disable iff (!rst_n) hold_chk |-> !vout_valid)
	else report_protocol_error("frame sent before it was marked processed");

	a_masked: assert property (@(posedge clk) disable iff (!rst_n)
		irq_off |-> !irq_filled && !irq_fetched)
	else report_protocol_error("interrupt raised while masked");

	a_filled_irq: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq_filled) |-> (in_cnt % FRAME_PIX) == 0)
	else report_protocol_error("filled interrupt before the frame was written");

	a_fetched_irq: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq_fetched) |-> (out_cnt % FRAME_PIX) == 0 && out_cnt == in_cnt)
	else report_protocol_error("fetched interrupt before the frame was read");

	// watchdog, 40 cycles per word of every frame in the run
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("timeout, run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h0753bafd));
		rst_n      = 1'b0;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		vin_pix    = '0;
		vin_valid  = 1'b0;
		vout_ready = 1'b0;
		ready_mode = RDY_LOW;
		gap_idx    = 0;
		in_cnt     = 0;
		out_cnt    = 0;
		val_errs   = 0;
		proto_errs = 0;
		dis_chk    = 1'b0;
		full_chk   = 1'b0;
		hold_chk   = 1'b0;
		irq_off    = 1'b1; // mask is zero out of reset
		for (int i = 0; i < GAP_LEN; i++) begin
			gap_pat[i] = ($urandom % 4) != 0; // about one stall in four
		end
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;

		// disabled, input offered and output ready, nothing moves
		dis_chk    = 1'b1;
		ready_mode = RDY_HIGH;
		apb_write(REG_SLOTS, SLOTS_S);
		vin_pix   = pixel_t'($urandom);
		vin_valid = 1'b1;
		repeat (20) @(posedge clk);
		#1 vin_valid = 1'b0;
		dis_chk = 1'b0;

		// back-pressure, output stalled so S+1 frames fill the ring
		ready_mode = RDY_LOW;
		apb_write(REG_CTRL, 32'h1);
		drive_pixels((SLOTS_S + 1) * FRAME_PIX);
		full_chk  = 1'b1;
		vin_pix   = pixel_t'($urandom);
		vin_valid = 1'b1;
		repeat (50) @(posedge clk);
		#1 vin_valid = 1'b0;
		full_chk = 1'b0;
		assert (in_cnt == (SLOTS_S + 1) * FRAME_PIX)
		else report_value_error($sformatf("%0d pixels accepted into a full ring", in_cnt));

		// release the output with random gaps, then stream more frames
		ready_mode = RDY_GAPS;
		wait_drain();
		drive_pixels(4 * FRAME_PIX);
		wait_drain();
		expect_status(2'b11); // set but masked

		// pos_proc holds the frame until software releases it
		apb_write(REG_STATUS, 32'h3);
		apb_write(REG_CTRL, 32'h3);
		hold_chk   = 1'b1;
		ready_mode = RDY_HIGH;
		drive_pixels(FRAME_PIX);
		repeat (2 * FRAME_WORDS) @(posedge clk);
		#1 hold_chk = 1'b0;
		apb_write(REG_PROC, 32'h1);
		wait_drain();

		// both interrupts unmasked
		apb_write(REG_STATUS, 32'h3);
		irq_off = 1'b0;
		apb_write(REG_CTRL, 32'h301);
		expect_status(2'b00);
		drive_pixels(FRAME_PIX);
		while (!irq_filled) @(negedge clk);
		while (!irq_fetched) @(negedge clk);
		@(posedge clk);
		#1;
		expect_status(2'b11);
		apb_write(REG_STATUS, 32'h3);
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (!irq_filled && !irq_fetched)
		else report_value_error("interrupts still high after status clear");
		@(posedge clk);
		#1;
		expect_status(2'b00);
		assert (out_cnt == in_cnt && exp_q.size() == 0)
		else report_value_error($sformatf("%0d pixels in, %0d out", in_cnt, out_cnt));

		$display("run done, %0d value errors, %0d protocol errors", val_errs, proto_errs);
		if (val_errs + proto_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* frame_buffer.f */
logic/fb_cfg_pkg.sv
logic/fb_stream_pkg.sv
logic/fb_reg_if.sv
logic/frame_writer.sv
logic/frame_store.sv
logic/frame_reader.sv
logic/frame_buffer.sv
bench/frame_buffer_tb.sv

/* Bender.yml */
package:
  name: frame_buffer

sources:
  # packages first, the rest depends on them
  - logic/fb_cfg_pkg.sv
  - logic/fb_stream_pkg.sv
  # rtl
  - logic/fb_reg_if.sv
  - logic/frame_writer.sv
  - logic/frame_store.sv
  - logic/frame_reader.sv
  - logic/frame_buffer.sv
  # testbench
  - target: test
    files:
      - bench/frame_buffer_tb.sv
